// File: compile.f
src/mm_format_pkg.sv
src/mm_stream_pkg.sv
src/axis_lane_if.sv
src/operand_ingress.sv
src/processing_element.sv
src/pe_grid.sv
src/result_drain.sv
src/fault_monitor.sv
src/systolic_mm_top.sv
tests/systolic_chk.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide on the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_top \
  -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } ||
  { grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }; }

// File: tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import mm_format_pkg::*;
  import mm_stream_pkg::*;

  localparam int NI = 2;
  localparam int NJ = 3;
  localparam int MAX_K = 8;
  localparam int NUM_JOBS = 16;
  // Worst-case operand and result words of one job
  localparam int JOB_WORDS = MAX_K * (NI + NJ) + NI * NJ;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * JOB_WORDS * 20 + 1000;

  logic                 clk;
  logic                 INTERNAL_RESET;
  logic [NI*16-1:0]     up_data;
  logic [NI-1:0]        up_valid;
  logic [NI-1:0]        up_last;
  logic [NI-1:0]        up_ready;
  logic [NJ*16-1:0]     left_data;
  logic [NJ-1:0]        left_valid;
  logic [NJ-1:0]        left_last;
  logic [NJ-1:0]        left_ready;
  logic [NI*16-1:0]     down_data;
  logic [NI-1:0]        down_valid;
  logic [NI-1:0]        down_last;
  logic [NI-1:0]        down_ready;
  logic                 err_unaligned;
  logic                 err_kind;
  logic                 core_rst;

  logic [15:0] a_mat [NJ][MAX_K];
  logic [15:0] b_mat [MAX_K][NI];
  logic [31:0] lcg_state = 32'h5376;
  int  up_idx [NI];
  int  up_len [NI];
  int  left_idx [NJ];
  int  left_len [NJ];
  bit  gaps_on = 0;
  bit  bp_on = 0;
  bit  abort_on_rst = 0;
  bit  saw_err = 0;
  bit  saw_core_rst = 0;

  systolic_mm_top #(
    .PE_NUM_I  (NI),
    .PE_NUM_J  (NJ),
    .SELF_RESET(1)
  ) dut_i (
    .clk(clk), .INTERNAL_RESET(INTERNAL_RESET),
    .up_data(up_data), .up_valid(up_valid), .up_last(up_last), .up_ready(up_ready),
    .left_data(left_data), .left_valid(left_valid), .left_last(left_last),
    .left_ready(left_ready),
    .down_data(down_data), .down_valid(down_valid), .down_last(down_last),
    .down_ready(down_ready),
    .err_unaligned(err_unaligned), .err_kind(err_kind), .core_rst(core_rst)
  );

  tb_checker #(.NI(NI)) chk_i (
    .clk(clk), .down_data(down_data), .down_valid(down_valid),
    .down_last(down_last), .down_ready(down_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Exact dot product with a floor shift by 12 and a clamp to signed 16 bits
  function automatic logic [15:0] ref_c(input int j, input int i, input int k_len);
    logic signed [39:0] sum;
    logic signed [39:0] a_ext;
    logic signed [39:0] b_ext;
    logic signed [39:0] shifted;
    sum = '0;
    for (int k = 0; k < k_len; k++) begin
      a_ext = $signed(a_mat[j][k]);
      b_ext = $signed(b_mat[k][i]);
      sum = sum + a_ext * b_ext;
    end
    shifted = sum >>> 12;
    if (shifted > 40'sd32767) return 16'h7fff;
    if (shifted < -40'sd32768) return 16'h8000;
    return shifted[15:0];
  endfunction

  // Sample handshakes at the falling edge and drive 1 ns after the rising edge
  task automatic step_cycle();
    logic [NI-1:0] up_fire;
    logic [NJ-1:0] left_fire;
    logic [31:0]   r;
    @(negedge clk);
    up_fire = up_valid & up_ready;
    left_fire = left_valid & left_ready;
    if (err_unaligned) saw_err = 1;
    if (core_rst) saw_core_rst = 1;
    @(posedge clk);
    #1;
    for (int i = 0; i < NI; i++) begin
      if (up_fire[i]) up_idx[i]++;
      if (abort_on_rst && saw_core_rst) begin
        up_valid[i] = 1'b0;
      end else if (!up_valid[i] || up_fire[i]) begin
        r = next_rand();
        up_valid[i] = (up_idx[i] < up_len[i]) && !(gaps_on && r[17:16] == 2'd0);
        if (up_valid[i]) begin
          up_data[i*16 +: 16] = b_mat[up_idx[i]][i];
          up_last[i] = (up_idx[i] == up_len[i] - 1);
        end
      end
    end
    for (int j = 0; j < NJ; j++) begin
      if (left_fire[j]) left_idx[j]++;
      if (abort_on_rst && saw_core_rst) begin
        left_valid[j] = 1'b0;
      end else if (!left_valid[j] || left_fire[j]) begin
        r = next_rand();
        left_valid[j] = (left_idx[j] < left_len[j]) && !(gaps_on && r[17:16] == 2'd0);
        if (left_valid[j]) begin
          left_data[j*16 +: 16] = a_mat[j][left_idx[j]];
          left_last[j] = (left_idx[j] == left_len[j] - 1);
        end
      end
    end
    for (int i = 0; i < NI; i++) begin
      r = next_rand();
      down_ready[i] = !bp_on || (r[17:16] != 2'd0);
    end
  endtask

  function automatic bit lanes_done();
    bit done;
    done = 1;
    for (int i = 0; i < NI; i++) if (up_idx[i] < up_len[i] || up_valid[i]) done = 0;
    for (int j = 0; j < NJ; j++) if (left_idx[j] < left_len[j] || left_valid[j]) done = 0;
    return done;
  endfunction

  // Misaligned jobs end the left streams one pair early and expect nothing
  task automatic run_job(input int k_len, input bit misalign);
    for (int i = 0; i < NI; i++) begin
      up_idx[i] = 0;
      up_len[i] = k_len;
    end
    for (int j = 0; j < NJ; j++) begin
      left_idx[j] = 0;
      left_len[j] = misalign ? k_len - 1 : k_len;
    end
    if (!misalign) begin
      for (int i = 0; i < NI; i++) begin
        for (int j = 0; j < NJ; j++) begin
          chk_i.push_expected(i, {j == NJ - 1, ref_c(j, i, k_len)});
        end
      end
    end
    do begin
      step_cycle();
    end while (!lanes_done() && !(abort_on_rst && saw_core_rst));
  endtask

  task automatic fill_random(input int k_len);
    logic [31:0] r;
    for (int k = 0; k < k_len; k++) begin
      for (int j = 0; j < NJ; j++) begin
        r = next_rand();
        a_mat[j][k] = 16'($signed(r[29:16]));
      end
      for (int i = 0; i < NI; i++) begin
        r = next_rand();
        b_mat[k][i] = 16'($signed(r[29:16]));
      end
    end
  endtask

  task automatic drain_results();
    while (chk_i.pending() > 0) step_cycle();
  endtask

  task automatic random_jobs(input int count);
    logic [31:0] r;
    int k_len;
    for (int n = 0; n < count; n++) begin
      r = next_rand();
      k_len = 1 + int'(r[18:16]);
      fill_random(k_len);
      run_job(k_len, 0);
    end
    drain_results();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: the run hung after %0d cycles with %0d results outstanding",
             WATCHDOG_CYCLES, chk_i.pending());
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    int n;
    INTERNAL_RESET = 1'b1;
    up_data = '0;
    up_valid = '0;
    up_last = '0;
    left_data = '0;
    left_valid = '0;
    left_last = '0;
    down_ready = '0;
    for (int i = 0; i < NI; i++) up_len[i] = 0;
    for (int j = 0; j < NJ; j++) left_len[j] = 0;
    repeat (2) @(posedge clk);
    #1;
    INTERNAL_RESET = 1'b0;

    // Reset release and a fixed K=3 job
    for (n = 0; n < 10; n++) begin
      @(negedge clk);
      if (!core_rst) break;
    end
    if (n < 4 || n > 5) chk_i.note_failure($sformatf("core_rst fell after %0d cycles", n));
    if (down_valid !== '0 || err_unaligned !== 1'b0 || err_kind !== 1'b0)
      chk_i.note_failure("outputs not idle after reset");
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < NJ; j++) a_mat[j][k] = 16'(((j + 1) * 16'h0800) - k * 16'h0400);
      b_mat[k][0] = 16'h1000 + 16'(k * 16'h0200);
      b_mat[k][1] = 16'hf000 + 16'(k * 16'h0100);
    end
    run_job(3, 0);
    drain_results();
    chk_i.end_test("reset_and_fixed_job");

    random_jobs(6);
    chk_i.end_test("random_jobs");

    gaps_on = 1;
    bp_on = 1;
    random_jobs(6);
    gaps_on = 0;
    bp_on = 0;
    chk_i.end_test("back_pressure");

    // Large magnitudes clamp rows 0 and 1 while row 2 stays in range
    for (int k = 0; k < MAX_K; k++) begin
      a_mat[0][k] = 16'h7fff;
      a_mat[1][k] = 16'h8000;
      a_mat[2][k] = 16'h0100;
      b_mat[k][0] = 16'h7fff;
      b_mat[k][1] = (k % 2 == 0) ? 16'h7000 : 16'h6000;
    end
    run_job(MAX_K, 0);
    drain_results();
    chk_i.end_test("saturation");

    fill_random(4);
    saw_err = 0;
    saw_core_rst = 0;
    abort_on_rst = 1;
    run_job(4, 1);
    for (n = 0; n < 20 && !saw_core_rst; n++) step_cycle();
    if (!saw_err) chk_i.note_failure("err_unaligned never rose on a misaligned job");
    if (!saw_core_rst) chk_i.note_failure("core_rst did not pulse after the error");
    abort_on_rst = 0;
    for (n = 0; n < 20 && core_rst; n++) step_cycle();
    repeat (2) step_cycle();
    if (core_rst || err_unaligned || err_kind)
      chk_i.note_failure("core did not recover from the error reset");
    fill_random(3);
    run_job(3, 0);
    drain_results();
    chk_i.end_test("misaligned_job");

    chk_i.summary();
    if (chk_i.err_count == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int NI = 2
) (
  input logic               clk,
  input logic [NI*16-1:0]   down_data,
  input logic [NI-1:0]      down_valid,
  input logic [NI-1:0]      down_last,
  input logic [NI-1:0]      down_ready
);

  // Expected words per column, {last, data}
  logic [16:0] exp_q [NI][$];
  int err_count = 0;
  int test_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int word_count = 0;

  function void push_expected(input int col, input logic [16:0] word);
    exp_q[col].push_back(word);
  endfunction

  function int pending();
    int n;
    n = 0;
    for (int i = 0; i < NI; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  function void note_failure(input string what);
    $display("failure at t=%0t: %s", $time, what);
    err_count++;
    test_errs++;
  endfunction

  function void end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endfunction

  function void summary();
    $display("summary: tests=%0d failed=%0d words=%0d errors=%0d",
             tests_run, tests_failed, word_count, err_count);
  endfunction

  // Valid, ready and data are all settled at the falling edge
  always @(negedge clk) begin : compare_words
    logic [16:0] w;
    for (int i = 0; i < NI; i++) begin
      if (down_valid[i] && down_ready[i]) begin
        word_count++;
        if (exp_q[i].size() == 0) begin
          note_failure($sformatf("column %0d produced a result nobody expected", i));
        end else begin
          w = exp_q[i].pop_front();
          if (down_data[i*16 +: 16] !== w[15:0]) begin
            $display("error t=%0t down_data[%0d] expected=%h actual=%h",
                     $time, i, w[15:0], down_data[i*16 +: 16]);
            err_count++;
            test_errs++;
          end
          if (down_last[i] !== w[16]) begin
            $display("error t=%0t down_last[%0d] expected=%b actual=%b",
                     $time, i, w[16], down_last[i]);
            err_count++;
            test_errs++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/systolic_chk.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_chk #(
  parameter int NI = 2,
  parameter int NJ = 3
) (
  input logic                               clk,
  input logic                               core_rst,
  input logic [NI*mm_format_pkg::RSLT_WIDTH-1:0] down_data,
  input logic [NI-1:0]                      down_valid,
  input logic [NI-1:0]                      down_last,
  input logic [NI-1:0]                      down_ready,
  input logic [NI-1:0]                      up_ready,
  input logic [NJ-1:0]                      left_ready
);
  import mm_format_pkg::*;

  int fail_count = 0;

  // A stalled result word must hold still
  for (genvar i = 0; i < NI; i++) begin : g_stable
    assert property (@(posedge clk) disable iff (core_rst)
      down_valid[i] && !down_ready[i] |=>
        $stable(down_data[i*RSLT_WIDTH +: RSLT_WIDTH]) && $stable(down_last[i]))
      else begin
        $error("down word on column %0d changed while stalled", i);
        fail_count++;
      end
  end

  // Registers clear one edge after core_rst rises
  assert property (@(posedge clk)
    core_rst && $past(core_rst) |-> !(|down_valid) && !(|up_ready) && !(|left_ready))
    else begin
      $error("handshake output active during core reset");
      fail_count++;
    end

  assert property (@(posedge clk)
    $fell(core_rst) |-> $past(core_rst, 2) && $past(core_rst, 3) && $past(core_rst, 4))
    else begin
      $error("core reset shorter than four cycles");
      fail_count++;
    end

endmodule

bind systolic_mm_top systolic_chk #(
  .NI(PE_NUM_I),
  .NJ(PE_NUM_J)
) assert_i (
  .clk       (clk),
  .core_rst  (core_rst),
  .down_data (down_data),
  .down_valid(down_valid),
  .down_last (down_last),
  .down_ready(down_ready),
  .up_ready  (up_ready),
  .left_ready(left_ready)
);

`default_nettype wire

// File: src/systolic_mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_mm_top #(
  parameter int PE_NUM_I = 2,
  parameter int PE_NUM_J = 3,
  parameter int SELF_RESET = 1
) (
  input  logic                                         clk,
  input  logic                                         INTERNAL_RESET,
  input  logic [PE_NUM_I*mm_stream_pkg::LANE_WIDTH-1:0] up_data,
  input  logic [PE_NUM_I-1:0]                          up_valid,
  input  logic [PE_NUM_I-1:0]                          up_last,
  output logic [PE_NUM_I-1:0]                          up_ready,
  input  logic [PE_NUM_J*mm_format_pkg::OP0_WIDTH-1:0] left_data,
  input  logic [PE_NUM_J-1:0]                          left_valid,
  input  logic [PE_NUM_J-1:0]                          left_last,
  output logic [PE_NUM_J-1:0]                          left_ready,
  output logic [PE_NUM_I*mm_format_pkg::RSLT_WIDTH-1:0] down_data,
  output logic [PE_NUM_I-1:0]                          down_valid,
  output logic [PE_NUM_I-1:0]                          down_last,
  input  logic [PE_NUM_I-1:0]                          down_ready,
  output logic                                         err_unaligned,
  output logic                                         err_kind,
  output logic                                         core_rst
);
  import mm_format_pkg::*;
  import mm_stream_pkg::*;

  logic [PE_NUM_I*PE_NUM_J-1:0] pe_err_unaligned;
  logic [PE_NUM_I*PE_NUM_J-1:0] pe_err_kind;

  axis_lane_if #(.WIDTH(LANE_WIDTH)) col_lane [PE_NUM_I] ();
  axis_lane_if #(.WIDTH(OP0_WIDTH))  row_lane [PE_NUM_J] ();
  axis_lane_if #(.WIDTH(LANE_WIDTH)) out_lane [PE_NUM_I] ();

  fault_monitor #(
    .SELF_RESET(SELF_RESET),
    .PE_NUM_I  (PE_NUM_I),
    .PE_NUM_J  (PE_NUM_J)
  ) fault_i (
    .clk             (clk),
    .INTERNAL_RESET  (INTERNAL_RESET),
    .pe_err_unaligned(pe_err_unaligned),
    .pe_err_kind     (pe_err_kind),
    .err_unaligned   (err_unaligned),
    .err_kind        (err_kind),
    .core_rst        (core_rst)
  );

  for (genvar i = 0; i < PE_NUM_I; i++) begin : g_col
    operand_ingress #(
      .WIDTH(LANE_WIDTH)
    ) up_ingress_i (
      .clk     (clk),
      .core_rst(core_rst),
      .in_data (up_data[i*LANE_WIDTH +: LANE_WIDTH]),
      .in_valid(up_valid[i]),
      .in_last (up_last[i]),
      .in_ready(up_ready[i]),
      .lane    (col_lane[i])
    );

    result_drain drain_i (
      .lane      (out_lane[i]),
      .down_data (down_data[i*RSLT_WIDTH +: RSLT_WIDTH]),
      .down_valid(down_valid[i]),
      .down_last (down_last[i]),
      .down_ready(down_ready[i])
    );
  end

  for (genvar j = 0; j < PE_NUM_J; j++) begin : g_row
    operand_ingress #(
      .WIDTH(OP0_WIDTH)
    ) left_ingress_i (
      .clk     (clk),
      .core_rst(core_rst),
      .in_data (left_data[j*OP0_WIDTH +: OP0_WIDTH]),
      .in_valid(left_valid[j]),
      .in_last (left_last[j]),
      .in_ready(left_ready[j]),
      .lane    (row_lane[j])
    );
  end

  pe_grid #(
    .PE_NUM_I(PE_NUM_I),
    .PE_NUM_J(PE_NUM_J)
  ) grid_i (
    .clk          (clk),
    .core_rst     (core_rst),
    .col_in       (col_lane),
    .row_in       (row_lane),
    .col_out      (out_lane),
    .err_unaligned(pe_err_unaligned),
    .err_kind     (pe_err_kind)
  );

endmodule

`default_nettype wire

// File: src/fault_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fault_monitor #(
  parameter int SELF_RESET = 1,
  parameter int PE_NUM_I = 2,
  parameter int PE_NUM_J = 3
) (
  input  logic                         clk,
  input  logic                         INTERNAL_RESET,
  input  logic [PE_NUM_I*PE_NUM_J-1:0] pe_err_unaligned,
  input  logic [PE_NUM_I*PE_NUM_J-1:0] pe_err_kind,
  output logic                         err_unaligned,
  output logic                         err_kind,
  output logic                         core_rst
);

  logic [3:0] rst_pipe;
  logic       rst_src;

  assign err_unaligned = |pe_err_unaligned;
  assign err_kind = |pe_err_kind;

  // Errors restart the core only when self reset is enabled
  assign rst_src = (SELF_RESET != 0) ? (INTERNAL_RESET || err_unaligned || err_kind) :
                   INTERNAL_RESET;

  always_ff @(posedge clk) begin
    rst_pipe <= {rst_pipe[2:0], rst_src};
  end

  // Stretches any source pulse to at least four cycles
  assign core_rst = |rst_pipe;

endmodule

`default_nettype wire

// File: src/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain (
  axis_lane_if.dst                           lane,
  output logic [mm_format_pkg::RSLT_WIDTH-1:0] down_data,
  output logic                               down_valid,
  output logic                               down_last,
  input  logic                               down_ready
);
  import mm_format_pkg::*;
  import mm_stream_pkg::*;

  logic is_result;

  assign is_result = lane.kind == RESULT;

  // Operands falling out of the bottom row are swallowed here
  assign lane.ready = (lane.valid && !is_result) || down_ready;

  assign down_valid = lane.valid && is_result;
  assign down_data = lane.data[RSLT_WIDTH-1:0];
  assign down_last = lane.last;

endmodule

`default_nettype wire

// File: src/pe_grid.sv
`timescale 1ns/1ps
`default_nettype none

module pe_grid #(
  parameter int PE_NUM_I = 2,
  parameter int PE_NUM_J = 3
) (
  input  logic                         clk,
  input  logic                         core_rst,
  axis_lane_if.dst                     col_in [PE_NUM_I],
  axis_lane_if.dst                     row_in [PE_NUM_J],
  axis_lane_if.src                     col_out [PE_NUM_I],
  output logic [PE_NUM_I*PE_NUM_J-1:0] err_unaligned,
  output logic [PE_NUM_I*PE_NUM_J-1:0] err_kind
);
  import mm_format_pkg::*;
  import mm_stream_pkg::*;

  // v_lane[j*PE_NUM_I+i] enters PE (j,i) from above; row PE_NUM_J is the bottom edge
  axis_lane_if #(.WIDTH(LANE_WIDTH)) v_lane [(PE_NUM_J+1)*PE_NUM_I] ();
  // h_lane[j*(PE_NUM_I+1)+i] enters PE (j,i) from the left; column PE_NUM_I is the right edge
  axis_lane_if #(.WIDTH(OP0_WIDTH)) h_lane [PE_NUM_J*(PE_NUM_I+1)] ();

  for (genvar i = 0; i < PE_NUM_I; i++) begin : g_col_edge
    localparam int BOTTOM = PE_NUM_J * PE_NUM_I + i;

    assign v_lane[i].data = col_in[i].data;
    assign v_lane[i].valid = col_in[i].valid;
    assign v_lane[i].last = col_in[i].last;
    assign v_lane[i].kind = col_in[i].kind;
    assign col_in[i].ready = v_lane[i].ready;

    assign col_out[i].data = v_lane[BOTTOM].data;
    assign col_out[i].valid = v_lane[BOTTOM].valid;
    assign col_out[i].last = v_lane[BOTTOM].last;
    assign col_out[i].kind = v_lane[BOTTOM].kind;
    assign v_lane[BOTTOM].ready = col_out[i].ready;
  end

  for (genvar j = 0; j < PE_NUM_J; j++) begin : g_row_edge
    localparam int FIRST = j * (PE_NUM_I + 1);

    assign h_lane[FIRST].data = row_in[j].data;
    assign h_lane[FIRST].valid = row_in[j].valid;
    assign h_lane[FIRST].last = row_in[j].last;
    assign h_lane[FIRST].kind = row_in[j].kind;
    assign row_in[j].ready = h_lane[FIRST].ready;

    // Operands leaving the last column are dropped
    assign h_lane[FIRST+PE_NUM_I].ready = 1'b1;
  end

  for (genvar j = 0; j < PE_NUM_J; j++) begin : g_row
    for (genvar i = 0; i < PE_NUM_I; i++) begin : g_col
      localparam int NODE = j * PE_NUM_I + i;
      localparam int H_IN = j * (PE_NUM_I + 1) + i;

      processing_element #(
        .PE_ROW(j)
      ) pe_i (
        .clk          (clk),
        .core_rst     (core_rst),
        .up           (v_lane[NODE]),
        .left         (h_lane[H_IN]),
        .down         (v_lane[NODE+PE_NUM_I]),
        .right        (h_lane[H_IN+1]),
        .err_unaligned(err_unaligned[NODE]),
        .err_kind     (err_kind[NODE])
      );
    end
  end

endmodule

`default_nettype wire

// File: src/processing_element.sv
`timescale 1ns/1ps
`default_nettype none

module processing_element #(
  parameter int PE_ROW = 0
) (
  input  logic     clk,
  input  logic     core_rst,
  axis_lane_if.dst up,
  axis_lane_if.dst left,
  axis_lane_if.src down,
  axis_lane_if.src right,
  output logic     err_unaligned,
  output logic     err_kind
);
  import mm_format_pkg::*;
  import mm_stream_pkg::*;

  // Counts results from above, 0 to PE_ROW-1
  localparam int CNT_WIDTH = (PE_ROW > 1) ? $clog2(PE_ROW) : 1;
  localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
    ACC_WIDTH'((64'sd1 <<< (RSLT_WIDTH - 1)) - 64'sd1);
  localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

  pe_state_e                           state;
  logic [CNT_WIDTH-1:0]                fwd_cnt;
  logic signed [ACC_WIDTH-1:0]         acc;
  logic signed [OP0_WIDTH+OP1_WIDTH-1:0] product;
  logic signed [ACC_WIDTH-1:0]         acc_sum;
  logic signed [ACC_WIDTH-1:0]         acc_shift;
  logic [RSLT_WIDTH-1:0]               result;

  // Right output register
  logic [OP0_WIDTH-1:0]  r_data;
  logic                  r_last;
  logic                  r_valid;

  // Down output register
  logic [LANE_WIDTH-1:0] d_data;
  logic                  d_last;
  logic                  d_valid;
  word_kind_e            d_kind;

  logic r_free;
  logic d_free;
  logic pair_ready;
  logic take;
  logic fwd_take;
  logic emit_load;
  logic d_load;
  logic pair_end;
  logic pair_split;
  logic kind_bad;

  assign r_free = !r_valid || right.ready;
  assign d_free = !d_valid || down.ready;

  // Both forward paths must have room before a pair is taken
  assign pair_ready = (state == COMPUTE) && r_free && d_free;
  assign take = pair_ready && up.valid && left.valid;
  assign fwd_take = (state == FORWARD) && up.valid && d_free;
  assign emit_load = (state == EMIT) && d_free;
  assign d_load = take || fwd_take || emit_load;

  assign left.ready = pair_ready && up.valid;
  assign up.ready = (pair_ready && left.valid) || ((state == FORWARD) && d_free);

  assign product = $signed(left.data[OP0_WIDTH-1:0]) * $signed(up.data[OP1_WIDTH-1:0]);
  assign acc_sum = acc + ACC_WIDTH'(product);

  // Floor rounding via arithmetic shift, then clamp to the result range
  assign acc_shift = acc >>> RSLT_SHIFT;

  always_comb begin
    if (acc_shift > SAT_MAX) begin
      result = SAT_MAX[RSLT_WIDTH-1:0];
    end else if (acc_shift < SAT_MIN) begin
      result = SAT_MIN[RSLT_WIDTH-1:0];
    end else begin
      result = acc_shift[RSLT_WIDTH-1:0];
    end
  end

  // Either side ending closes the job, a mismatch is flagged below
  assign pair_end = left.last || up.last;
  assign pair_split = left.last != up.last;

  assign kind_bad = up.valid && (((state == COMPUTE) && (up.kind == RESULT)) ||
                                 ((state == FORWARD) && (up.kind == OPERAND)));

  always_ff @(posedge clk) begin
    if (core_rst) begin
      state <= COMPUTE;
      fwd_cnt <= '0;
      acc <= '0;
    end else begin
      case (state)
        COMPUTE: begin
          if (take) begin
            acc <= acc_sum;
            if (pair_end) begin
              // Top row has nothing to pass on
              state <= (PE_ROW == 0) ? EMIT : FORWARD;
            end
          end
        end
        FORWARD: begin
          if (fwd_take) begin
            if (fwd_cnt == CNT_WIDTH'(PE_ROW - 1)) begin
              fwd_cnt <= '0;
              state <= EMIT;
            end else begin
              fwd_cnt <= fwd_cnt + 1'b1;
            end
          end
        end
        EMIT: begin
          if (emit_load) begin
            acc <= '0;
            state <= COMPUTE;
          end
        end
        default: state <= COMPUTE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      r_valid <= 1'b0;
      d_valid <= 1'b0;
    end else begin
      if (take) begin
        r_valid <= 1'b1;
      end else if (right.ready) begin
        r_valid <= 1'b0;
      end
      if (d_load) begin
        d_valid <= 1'b1;
      end else if (down.ready) begin
        d_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      r_data <= left.data;
      r_last <= left.last;
      d_data <= up.data;
      d_last <= up.last;
      d_kind <= OPERAND;
    end else if (fwd_take) begin
      // Results from above never end the column
      d_data <= up.data;
      d_last <= 1'b0;
      d_kind <= RESULT;
    end else if (emit_load) begin
      d_data <= LANE_WIDTH'($signed(result));
      d_last <= 1'b1;
      d_kind <= RESULT;
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (core_rst) begin
      err_unaligned <= 1'b0;
      err_kind <= 1'b0;
    end else begin
      if (take && pair_split) begin
        err_unaligned <= 1'b1;
      end
      if (kind_bad) begin
        err_kind <= 1'b1;
      end
    end
  end

  assign right.data = r_data;
  assign right.valid = r_valid;
  assign right.last = r_last;
  assign right.kind = OPERAND;

  assign down.data = d_data;
  assign down.valid = d_valid;
  assign down.last = d_last;
  assign down.kind = d_kind;

endmodule

`default_nettype wire

// File: src/operand_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module operand_ingress #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             core_rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  input  logic             in_last,
  output logic             in_ready,
  axis_lane_if.src         lane
);
  import mm_stream_pkg::*;

  logic [WIDTH-1:0] out_data;
  logic             out_last;
  logic             out_valid;
  logic [WIDTH-1:0] skid_data;
  logic             skid_last;
  logic             skid_valid;
  logic             accept;
  logic             out_free;
  logic             out_load;
  logic             skid_load;
  logic             out_valid_next;
  logic             skid_valid_next;

  assign accept = in_valid && in_ready;

  // Output stage can take a word when empty or draining this cycle
  assign out_free = !out_valid || lane.ready;

  // A parked word always refills the output before new input
  assign out_load = out_free && (skid_valid || accept);
  assign skid_load = accept && !out_free;

  always_comb begin
    out_valid_next = out_valid;
    skid_valid_next = skid_valid;
    if (out_free) begin
      out_valid_next = skid_valid || accept;
      skid_valid_next = 1'b0;
    end else if (accept) begin
      skid_valid_next = 1'b1;
    end
  end

  // Ready is registered, so it only drops once both entries hold a word
  always_ff @(posedge clk) begin
    if (core_rst) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready <= 1'b0;
    end else begin
      out_valid <= out_valid_next;
      skid_valid <= skid_valid_next;
      in_ready <= !skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= skid_valid ? skid_data : in_data;
      out_last <= skid_valid ? skid_last : in_last;
    end
    if (skid_load) begin
      skid_data <= in_data;
      skid_last <= in_last;
    end
  end

  assign lane.data = out_data;
  assign lane.valid = out_valid;
  assign lane.last = out_last;
  // Edge streams only ever carry operands
  assign lane.kind = OPERAND;

endmodule

`default_nettype wire

// File: src/axis_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axis_lane_if #(
  parameter int WIDTH = mm_stream_pkg::LANE_WIDTH
);
  import mm_stream_pkg::*;

  logic [WIDTH-1:0] data;
  logic             valid;
  logic             ready;
  logic             last;
  word_kind_e       kind;

  // Producer side
  modport src (output data, output valid, output last, output kind, input ready);

  // Consumer side
  modport dst (input data, input valid, input last, input kind, output ready);

endinterface

`default_nettype wire

// File: src/mm_stream_pkg.sv
`default_nettype none

package mm_stream_pkg;

  // Tags every word on a lane
  typedef enum logic {
    OPERAND = 1'b0,
    RESULT  = 1'b1
  } word_kind_e;

  typedef enum logic [1:0] {
    COMPUTE = 2'd0,
    FORWARD = 2'd1,
    EMIT    = 2'd2
  } pe_state_e;

  // Vertical lanes carry both up operands and results
  localparam int LANE_WIDTH = (mm_format_pkg::OP1_WIDTH > mm_format_pkg::RSLT_WIDTH) ?
                              mm_format_pkg::OP1_WIDTH : mm_format_pkg::RSLT_WIDTH;

endpackage

`default_nettype wire

// File: src/mm_format_pkg.sv
`default_nettype none

package mm_format_pkg;

  // Left operand, signed Q3.12
  localparam int OP0_WIDTH = 16;
  localparam int OP0_FRAC = 12;

  // Up operand, signed Q3.12
  localparam int OP1_WIDTH = 16;
  localparam int OP1_FRAC = 12;

  // Result, signed Q3.12
  localparam int RSLT_WIDTH = 16;
  localparam int RSLT_FRAC = 12;

  // 32-bit product plus 8 guard bits, exact for up to 256 terms
  localparam int ACC_WIDTH = 40;

  // Alignment from product format to result format
  localparam int RSLT_SHIFT = OP0_FRAC + OP1_FRAC - RSLT_FRAC;

endpackage

`default_nettype wire
